/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Mdir obj_dir
TOP      = tb_cpu_core
FILELIST = vlog.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* cpu_core.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
  input  wire                     clock,
  input  wire                     arst_n,
  // instruction sram
  output wire                     inst_en,
  output wire cpu_pkg::strobe_t   inst_wstrb,
  output wire cpu_pkg::word_t     inst_addr,
  output wire cpu_pkg::word_t     inst_wdata,
  input  wire cpu_pkg::word_t     inst_rdata,
  // data sram
  output wire                     data_en,
  output wire cpu_pkg::strobe_t   data_wstrb,
  output wire cpu_pkg::word_t     data_addr,
  output wire cpu_pkg::word_t     data_wdata,
  input  wire cpu_pkg::word_t     data_rdata,
  // retire trace
  output wire cpu_pkg::word_t     debug_pc,
  output wire cpu_pkg::strobe_t   debug_rf_wstrb,
  output wire cpu_pkg::reg_addr_t debug_rf_waddr,
  output wire cpu_pkg::word_t     debug_rf_wdata
);
  import cpu_pkg::*;

  // handshake
  wire id_allow_in;
  wire ex_allow_in;
  wire mem_allow_in;
  // write-back has no downstream stage
  wire wb_allow_in = 1'b1;

  // fetch to decode, and branch redirect back
  wire       fs_valid;
  wire word_t fs_pc;
  wire word_t fs_inst;
  wire       br_taken;
  wire word_t br_target;

  // decode to execute
  wire          ds_valid;
  wire word_t   ds_pc;
  wire alu_op_t alu_op;
  wire word_t   alu_src1;
  wire word_t   alu_src2;
  wire          mem_read;
  wire          mem_write;
  wire word_t   store_data;
  wire reg_addr_t dest;
  wire          dest_we;

  // execute to memory access
  wire            es_valid;
  wire word_t     es_pc;
  wire word_t     es_result;
  wire            es_mem_read;
  wire reg_addr_t es_dest;
  wire            es_dest_we;

  // memory access to write-back
  wire            ms_valid;
  wire word_t     ms_pc;
  wire word_t     ms_result;
  wire reg_addr_t ms_dest;
  wire            ms_dest_we;

  // forwarding into decode
  wire            es_fwd_valid, es_fwd_we, es_is_load;
  wire reg_addr_t es_fwd_dest;
  wire word_t     es_fwd_value;
  wire            ms_fwd_valid, ms_fwd_we;
  wire reg_addr_t ms_fwd_dest;
  wire word_t     ms_fwd_value;
  wire            ws_fwd_valid, ws_fwd_we;
  wire reg_addr_t ws_fwd_dest;
  wire word_t     ws_fwd_value;

  // register file ports
  wire reg_addr_t rf_raddr1;
  wire reg_addr_t rf_raddr2;
  wire word_t     rf_rdata1;
  wire word_t     rf_rdata2;
  wire            rf_we;
  wire reg_addr_t rf_waddr;
  wire word_t     rf_wdata;

  if_stage u_if_stage (.*);

  id_stage u_id_stage (.*);

  ex_stage u_ex_stage (.*);

  mem_stage u_mem_stage (.*);

  wb_stage u_wb_stage (.*);

  register_file u_register_file (.*);

endmodule : cpu_core

`default_nettype wire

/* cpu_core_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_core_sva (
  input wire                   clock,
  input wire                   arst_n,
  input wire cpu_pkg::strobe_t inst_wstrb,
  input wire                   data_en,
  input wire cpu_pkg::strobe_t data_wstrb,
  input wire cpu_pkg::word_t   debug_pc,
  input wire cpu_pkg::strobe_t debug_rf_wstrb,
  input wire                   fs_valid,
  input wire                   ds_valid,
  input wire                   es_valid,
  input wire                   ms_valid,
  input wire                   ws_valid
);

  // instruction port never writes
  inst_read_only: assert property (@(posedge clock) inst_wstrb == 4'h0)
    else $error("inst_wstrb is nonzero");

  data_strobe_needs_enable: assert property (
    @(posedge clock) disable iff (!arst_n) data_wstrb != 4'h0 |-> data_en)
    else $error("data_wstrb set without data_en");

  trace_pc_aligned: assert property (
    @(posedge clock) disable iff (!arst_n) debug_rf_wstrb != 4'h0 |-> debug_pc[1:0] == 2'b00)
    else $error("debug_pc not word aligned on a trace write");

  // pipeline empty while reset is held
  no_valid_in_reset: assert property (
    @(posedge clock) !arst_n |-> !(fs_valid || ds_valid || es_valid || ms_valid || ws_valid))
    else $error("valid bit high during reset");

endmodule : cpu_core_sva

bind cpu_core cpu_core_sva u_sva (
  .clock          (clock),
  .arst_n         (arst_n),
  .inst_wstrb     (inst_wstrb),
  .data_en        (data_en),
  .data_wstrb     (data_wstrb),
  .debug_pc       (debug_pc),
  .debug_rf_wstrb (debug_rf_wstrb),
  .fs_valid       (fs_valid),
  .ds_valid       (ds_valid),
  .es_valid       (es_valid),
  .ms_valid       (ms_valid),
  .ws_valid       (ws_fwd_valid)
);

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  strobe_t;
  typedef logic [3:0]  alu_op_t;

  // alu operations
  localparam alu_op_t alu_add = 4'd0;
  localparam alu_op_t alu_sub = 4'd1;
  localparam alu_op_t alu_and = 4'd2;
  localparam alu_op_t alu_or  = 4'd3;
  localparam alu_op_t alu_xor = 4'd4;
  localparam alu_op_t alu_slt = 4'd5;
  localparam alu_op_t alu_sll = 4'd6;
  localparam alu_op_t alu_srl = 4'd7;
  // places src2[15:0] in the upper half
  localparam alu_op_t alu_lui = 4'd8;

  // primary opcodes, inst[31:26]
  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_j       = 6'h02;
  localparam logic [5:0] op_beq     = 6'h04;
  localparam logic [5:0] op_bne     = 6'h05;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_ori     = 6'h0d;
  localparam logic [5:0] op_lui     = 6'h0f;
  localparam logic [5:0] op_lw      = 6'h23;
  localparam logic [5:0] op_sw      = 6'h2b;

  // function codes under op_special, inst[5:0]
  localparam logic [5:0] fn_sll  = 6'h00;
  localparam logic [5:0] fn_srl  = 6'h02;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_xor  = 6'h26;
  localparam logic [5:0] fn_slt  = 6'h2a;

  // first fetch address
  localparam word_t reset_pc = 32'h0000_0000;

endpackage : cpu_pkg

`default_nettype wire

/* ex_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_stage (
  input  wire                       clock,
  input  wire                       arst_n,
  input  wire                       mem_allow_in,
  input  wire                       ds_valid,
  input  wire cpu_pkg::word_t       ds_pc,
  input  wire cpu_pkg::alu_op_t     alu_op,
  input  wire cpu_pkg::word_t       alu_src1,
  input  wire cpu_pkg::word_t       alu_src2,
  input  wire                       mem_read,
  input  wire                       mem_write,
  input  wire cpu_pkg::word_t       store_data,
  input  wire cpu_pkg::reg_addr_t   dest,
  input  wire                       dest_we,
  output logic                      ex_allow_in,
  output logic                      es_valid,
  output cpu_pkg::word_t            es_pc,
  output cpu_pkg::word_t            es_result,
  output logic                      es_mem_read,
  output cpu_pkg::reg_addr_t        es_dest,
  output logic                      es_dest_we,
  output logic                      es_fwd_valid,
  output logic                      es_fwd_we,
  output cpu_pkg::reg_addr_t        es_fwd_dest,
  output cpu_pkg::word_t            es_fwd_value,
  output logic                      es_is_load,
  output logic                      data_en,
  output cpu_pkg::strobe_t          data_wstrb,
  output cpu_pkg::word_t            data_addr,
  output cpu_pkg::word_t            data_wdata
);
  import cpu_pkg::*;

  alu_op_t op;
  word_t   src1;
  word_t   src2;
  logic    is_store;
  word_t   wdata;
  logic    move_on;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      es_valid <= 1'b0;
    end else if (ex_allow_in) begin
      es_valid <= ds_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (ds_valid && ex_allow_in) begin
      es_pc       <= ds_pc;
      op          <= alu_op;
      src1        <= alu_src1;
      src2        <= alu_src2;
      es_mem_read <= mem_read;
      is_store    <= mem_write;
      wdata       <= store_data;
      es_dest     <= dest;
      es_dest_we  <= dest_we;
    end
  end

  assign ex_allow_in = !es_valid || mem_allow_in;

  always_comb begin
    case (op)
      alu_add: es_result = src1 + src2;
      alu_sub: es_result = src1 - src2;
      alu_and: es_result = src1 & src2;
      alu_or:  es_result = src1 | src2;
      alu_xor: es_result = src1 ^ src2;
      alu_slt: es_result = {31'b0, $signed(src1) < $signed(src2)};
      alu_sll: es_result = src2 << src1[4:0];
      alu_srl: es_result = src2 >> src1[4:0];
      alu_lui: es_result = {src2[15:0], 16'b0};
      default: es_result = src1 + src2;
    endcase
  end

  assign es_fwd_valid = es_valid;
  assign es_fwd_we    = es_dest_we;
  assign es_fwd_dest  = es_dest;
  assign es_fwd_value = es_result;
  assign es_is_load   = es_mem_read;

  // request goes out as the item enters memory access, address is the alu sum
  assign move_on    = es_valid && mem_allow_in;
  assign data_en    = move_on && (es_mem_read || is_store);
  assign data_wstrb = (move_on && is_store) ? 4'hf : 4'h0;
  assign data_addr  = es_result;
  assign data_wdata = wdata;

endmodule : ex_stage

`default_nettype wire

/* id_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module id_stage (
  input  wire                     clock,
  input  wire                     arst_n,
  input  wire                     ex_allow_in,
  input  wire                     fs_valid,
  input  wire cpu_pkg::word_t     fs_pc,
  input  wire cpu_pkg::word_t     fs_inst,
  input  wire                     es_fwd_valid,
  input  wire                     es_fwd_we,
  input  wire cpu_pkg::reg_addr_t es_fwd_dest,
  input  wire cpu_pkg::word_t     es_fwd_value,
  input  wire                     es_is_load,
  input  wire                     ms_fwd_valid,
  input  wire                     ms_fwd_we,
  input  wire cpu_pkg::reg_addr_t ms_fwd_dest,
  input  wire cpu_pkg::word_t     ms_fwd_value,
  input  wire                     ws_fwd_valid,
  input  wire                     ws_fwd_we,
  input  wire cpu_pkg::reg_addr_t ws_fwd_dest,
  input  wire cpu_pkg::word_t     ws_fwd_value,
  input  wire cpu_pkg::word_t     rf_rdata1,
  input  wire cpu_pkg::word_t     rf_rdata2,
  output logic                    id_allow_in,
  output cpu_pkg::reg_addr_t      rf_raddr1,
  output cpu_pkg::reg_addr_t      rf_raddr2,
  output logic                    br_taken,
  output cpu_pkg::word_t          br_target,
  output logic                    ds_valid,
  output cpu_pkg::word_t          ds_pc,
  output cpu_pkg::alu_op_t        alu_op,
  output cpu_pkg::word_t          alu_src1,
  output cpu_pkg::word_t          alu_src2,
  output logic                    mem_read,
  output logic                    mem_write,
  output cpu_pkg::word_t          store_data,
  output cpu_pkg::reg_addr_t      dest,
  output logic                    dest_we
);
  import cpu_pkg::*;

  logic       valid;
  word_t      inst;
  logic [5:0] opcode;
  logic [5:0] funct;
  reg_addr_t  rs;
  reg_addr_t  rt;
  word_t      imm_sext;
  word_t      imm_zext;
  word_t      rs_value;
  word_t      rt_value;
  word_t      pc_plus4;
  logic       is_rtype, is_shift, is_addiu, is_ori, is_lui;
  logic       is_lw, is_sw, is_beq, is_bne, is_j;
  logic       use_rs, use_rt;
  logic       load_hazard;
  logic       ready_go;
  logic       br_cond;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid <= 1'b0;
    end else if (id_allow_in) begin
      valid <= fs_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (fs_valid && id_allow_in) begin
      ds_pc <= fs_pc;
      inst  <= fs_inst;
    end
  end

  // instruction fields
  assign opcode   = inst[31:26];
  assign rs       = inst[25:21];
  assign rt       = inst[20:16];
  assign funct    = inst[5:0];
  assign imm_sext = {{16{inst[15]}}, inst[15:0]};
  assign imm_zext = {16'b0, inst[15:0]};

  assign is_rtype = opcode == op_special;
  assign is_shift = is_rtype && (funct == fn_sll || funct == fn_srl);
  assign is_addiu = opcode == op_addiu;
  assign is_ori   = opcode == op_ori;
  assign is_lui   = opcode == op_lui;
  assign is_lw    = opcode == op_lw;
  assign is_sw    = opcode == op_sw;
  assign is_beq   = opcode == op_beq;
  assign is_bne   = opcode == op_bne;
  assign is_j     = opcode == op_j;

  assign use_rs = !is_shift && !is_lui && !is_j;
  assign use_rt = is_rtype || is_sw || is_beq || is_bne;

  // youngest matching stage wins
  function automatic word_t forward(input reg_addr_t addr, input word_t rf_value);
    if (addr == '0) begin
      return '0;
    end
    if (es_fwd_valid && es_fwd_we && es_fwd_dest == addr) begin
      return es_fwd_value;
    end
    if (ms_fwd_valid && ms_fwd_we && ms_fwd_dest == addr) begin
      return ms_fwd_value;
    end
    if (ws_fwd_valid && ws_fwd_we && ws_fwd_dest == addr) begin
      return ws_fwd_value;
    end
    return rf_value;
  endfunction

  assign rf_raddr1 = rs;
  assign rf_raddr2 = rt;

  always_comb begin
    rs_value = forward(rs, rf_rdata1);
    rt_value = forward(rt, rf_rdata2);
  end

  // load data only exists once the load reaches memory access
  assign load_hazard = es_is_load && es_fwd_valid && es_fwd_we && es_fwd_dest != '0 &&
                       ((use_rs && es_fwd_dest == rs) || (use_rt && es_fwd_dest == rt));

  assign ready_go    = !load_hazard;
  assign id_allow_in = !valid || (ready_go && ex_allow_in);
  assign ds_valid    = valid && ready_go;

  // branch and jump resolution
  assign pc_plus4  = ds_pc + 32'd4;
  assign br_cond   = is_j || (is_beq && rs_value == rt_value) ||
                     (is_bne && rs_value != rt_value);
  assign br_taken  = valid && ready_go && ex_allow_in && br_cond;
  assign br_target = is_j ? {pc_plus4[31:28], inst[25:0], 2'b00}
                          : pc_plus4 + {imm_sext[29:0], 2'b00};

  always_comb begin
    alu_op = alu_add;
    if (is_rtype) begin
      case (funct)
        fn_subu: alu_op = alu_sub;
        fn_and:  alu_op = alu_and;
        fn_or:   alu_op = alu_or;
        fn_xor:  alu_op = alu_xor;
        fn_slt:  alu_op = alu_slt;
        fn_sll:  alu_op = alu_sll;
        fn_srl:  alu_op = alu_srl;
        default: alu_op = alu_add;
      endcase
    end else if (is_ori) begin
      alu_op = alu_or;
    end else if (is_lui) begin
      alu_op = alu_lui;
    end
  end

  // shifts take the amount from the sa field
  assign alu_src1 = is_shift ? {27'b0, inst[10:6]} : rs_value;
  assign alu_src2 = is_rtype ? rt_value :
                    (is_ori || is_lui) ? imm_zext : imm_sext;

  assign mem_read   = is_lw;
  assign mem_write  = is_sw;
  assign store_data = rt_value;
  assign dest       = is_rtype ? inst[15:11] : rt;
  assign dest_we    = is_rtype || is_addiu || is_ori || is_lui || is_lw;

endmodule : id_stage

`default_nettype wire

/* if_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module if_stage (
  input  wire                 clock,
  input  wire                 arst_n,
  input  wire                 id_allow_in,
  input  wire                 br_taken,
  input  wire cpu_pkg::word_t br_target,
  input  wire cpu_pkg::word_t inst_rdata,
  output logic                fs_valid,
  output cpu_pkg::word_t      fs_pc,
  output cpu_pkg::word_t      fs_inst,
  output logic                inst_en,
  output cpu_pkg::strobe_t    inst_wstrb,
  output cpu_pkg::word_t      inst_addr,
  output cpu_pkg::word_t      inst_wdata
);
  import cpu_pkg::*;

  logic  fetch_on;
  logic  fs_allow_in;
  word_t next_pc;

  // requests start one edge after reset is released
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      fetch_on <= 1'b0;
    end else begin
      fetch_on <= 1'b1;
    end
  end

  assign fs_allow_in = !fs_valid || id_allow_in;

  // fs_pc holds the delay slot while decode resolves a branch
  assign next_pc = br_taken ? br_target : fs_pc + 32'd4;

  // pc starts one word early so the first sequential fetch hits reset_pc
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      fs_valid <= 1'b0;
      fs_pc    <= reset_pc - 32'd4;
    end else if (fetch_on && fs_allow_in) begin
      fs_valid <= 1'b1;
      fs_pc    <= next_pc;
    end
  end

  // on a stall ask for fs_pc again so inst_rdata keeps the held word
  assign inst_en    = fetch_on;
  assign inst_addr  = fs_allow_in ? next_pc : fs_pc;
  assign inst_wstrb = '0;
  assign inst_wdata = '0;

  assign fs_inst = inst_rdata;

endmodule : if_stage

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
  input  wire                     clock,
  input  wire                     arst_n,
  input  wire                     wb_allow_in,
  input  wire                     es_valid,
  input  wire cpu_pkg::word_t     es_pc,
  input  wire cpu_pkg::word_t     es_result,
  input  wire                     es_mem_read,
  input  wire cpu_pkg::reg_addr_t es_dest,
  input  wire                     es_dest_we,
  input  wire cpu_pkg::word_t     data_rdata,
  output logic                    mem_allow_in,
  output logic                    ms_valid,
  output cpu_pkg::word_t          ms_pc,
  output cpu_pkg::word_t          ms_result,
  output cpu_pkg::reg_addr_t      ms_dest,
  output logic                    ms_dest_we,
  output logic                    ms_fwd_valid,
  output logic                    ms_fwd_we,
  output cpu_pkg::reg_addr_t      ms_fwd_dest,
  output cpu_pkg::word_t          ms_fwd_value
);
  import cpu_pkg::*;

  word_t alu_result;
  logic  is_load;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ms_valid <= 1'b0;
    end else if (mem_allow_in) begin
      ms_valid <= es_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (es_valid && mem_allow_in) begin
      ms_pc      <= es_pc;
      alu_result <= es_result;
      is_load    <= es_mem_read;
      ms_dest    <= es_dest;
      ms_dest_we <= es_dest_we;
    end
  end

  assign mem_allow_in = !ms_valid || wb_allow_in;

  // sram answers in the cycle after the request from execute
  assign ms_result = is_load ? data_rdata : alu_result;

  assign ms_fwd_valid = ms_valid;
  assign ms_fwd_we    = ms_dest_we;
  assign ms_fwd_dest  = ms_dest;
  assign ms_fwd_value = ms_result;

endmodule : mem_stage

`default_nettype wire

/* register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file (
  input  wire                     clock,
  input  wire                     arst_n,
  input  wire cpu_pkg::reg_addr_t rf_raddr1,
  input  wire cpu_pkg::reg_addr_t rf_raddr2,
  output cpu_pkg::word_t          rf_rdata1,
  output cpu_pkg::word_t          rf_rdata2,
  input  wire                     rf_we,
  input  wire cpu_pkg::reg_addr_t rf_waddr,
  input  wire cpu_pkg::word_t     rf_wdata
);
  import cpu_pkg::*;

  word_t regs [32];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we && rf_waddr != '0) begin
      regs[rf_waddr] <= rf_wdata;
    end
  end

  // a write in the same cycle is seen by the read, $0 always reads zero
  assign rf_rdata1 = (rf_raddr1 == '0) ? '0 :
                     (rf_we && rf_waddr == rf_raddr1) ? rf_wdata : regs[rf_raddr1];
  assign rf_rdata2 = (rf_raddr2 == '0) ? '0 :
                     (rf_we && rf_waddr == rf_raddr2) ? rf_wdata : regs[rf_raddr2];

endmodule : register_file

`default_nettype wire

/* tb_cpu_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_core;
  import cpu_pkg::*;

  localparam int fetch_timeout = 20;
  localparam int trace_timeout = 40;
  localparam int quiet_cycles  = 50;

  logic      clock;
  logic      arst_n;
  wire       inst_en;
  strobe_t   inst_wstrb;
  word_t     inst_addr;
  word_t     inst_wdata;
  word_t     inst_rdata;
  wire       data_en;
  strobe_t   data_wstrb;
  word_t     data_addr;
  word_t     data_wdata;
  word_t     data_rdata;
  word_t     debug_pc;
  strobe_t   debug_rf_wstrb;
  reg_addr_t debug_rf_waddr;
  word_t     debug_rf_wdata;

  // both srams hold 256 words
  word_t imem [256];
  word_t dmem [256];

  // program words from reset_pc upward
  word_t     program_table [$];
  // retired writes in program order
  word_t     exp_pc  [$];
  reg_addr_t exp_reg [$];
  word_t     exp_val [$];

  cpu_core dut (.*);

  always #10 clock = ~clock;

  // one-cycle registered reads, byte strobe writes
  always @(posedge clock) begin
    if (inst_en) begin
      for (int b = 0; b < 4; b++) begin
        if (inst_wstrb[b]) begin
          imem[inst_addr[9:2]][8*b +: 8] <= inst_wdata[8*b +: 8];
        end
      end
      inst_rdata <= imem[inst_addr[9:2]];
    end
  end

  always @(posedge clock) begin
    if (data_en) begin
      for (int b = 0; b < 4; b++) begin
        if (data_wstrb[b]) begin
          dmem[data_addr[9:2]][8*b +: 8] <= data_wdata[8*b +: 8];
        end
      end
      data_rdata <= dmem[data_addr[9:2]];
    end
  end

  function automatic word_t rtype_word(input reg_addr_t rs, input reg_addr_t rt,
                                       input reg_addr_t rd, input logic [4:0] sa,
                                       input logic [5:0] fn);
    return {op_special, rs, rt, rd, sa, fn};
  endfunction

  function automatic word_t itype_word(input logic [5:0] op, input reg_addr_t rs,
                                       input reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jump_word(input word_t target);
    return {op_j, target[27:2]};
  endfunction

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_reg_addr(input string name, input reg_addr_t expected,
                                input reg_addr_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("[ERROR] %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  task automatic check_strobe(input string name, input strobe_t expected, input strobe_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("[ERROR] %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  // unused words decode as no-ops and still depend on the address
  task automatic fill_memories();
    for (int i = 0; i < 256; i++) begin
      imem[8'(i)] <= 32'hdc00_0000 | word_t'(i * 4);
      dmem[8'(i)] <= 32'h5a5a_0000 | word_t'(i * 4);
    end
  endtask

  task automatic load_program();
    logic [7:0] base;
    base = reset_pc[9:2];
    // forwarding chain
    program_table.push_back(itype_word(op_lui, 5'd0, 5'd1, 16'h1234));        // 00
    program_table.push_back(itype_word(op_ori, 5'd1, 5'd1, 16'h5678));        // 04
    program_table.push_back(itype_word(op_addiu, 5'd0, 5'd2, 16'd100));       // 08
    program_table.push_back(rtype_word(5'd1, 5'd2, 5'd3, 5'd0, fn_addu));     // 0c
    program_table.push_back(rtype_word(5'd3, 5'd1, 5'd4, 5'd0, fn_subu));     // 10
    program_table.push_back(rtype_word(5'd3, 5'd1, 5'd5, 5'd0, fn_xor));      // 14
    program_table.push_back(rtype_word(5'd2, 5'd5, 5'd6, 5'd0, fn_slt));      // 18
    program_table.push_back(rtype_word(5'd0, 5'd6, 5'd7, 5'd4, fn_sll));      // 1c
    program_table.push_back(rtype_word(5'd0, 5'd1, 5'd8, 5'd8, fn_srl));      // 20
    program_table.push_back(rtype_word(5'd5, 5'd7, 5'd9, 5'd0, fn_or));       // 24
    // store, load and load-use
    program_table.push_back(itype_word(op_addiu, 5'd0, 5'd10, 16'h0040));     // 28
    program_table.push_back(itype_word(op_sw, 5'd10, 5'd1, 16'd4));           // 2c
    program_table.push_back(itype_word(op_lw, 5'd10, 5'd11, 16'd4));          // 30
    program_table.push_back(rtype_word(5'd11, 5'd2, 5'd12, 5'd0, fn_addu));   // 34
    // branches with delay slots
    program_table.push_back(itype_word(op_beq, 5'd12, 5'd3, 16'd2));          // 38
    program_table.push_back(itype_word(op_addiu, 5'd0, 5'd13, 16'd1));        // 3c
    program_table.push_back(itype_word(op_addiu, 5'd0, 5'd14, 16'd2));        // 40
    program_table.push_back(itype_word(op_bne, 5'd13, 5'd0, 16'd2));          // 44
    program_table.push_back(itype_word(op_addiu, 5'd0, 5'd15, 16'd3));        // 48
    program_table.push_back(itype_word(op_addiu, 5'd0, 5'd14, 16'd4));        // 4c
    program_table.push_back(itype_word(op_beq, 5'd13, 5'd0, 16'd5));          // 50
    program_table.push_back(itype_word(op_addiu, 5'd0, 5'd16, 16'd5));        // 54
    program_table.push_back(itype_word(op_addiu, 5'd0, 5'd17, 16'd6));        // 58
    program_table.push_back(jump_word(32'h0000_0080));                        // 5c
    program_table.push_back(itype_word(op_addiu, 5'd0, 5'd18, 16'd7));        // 60
    // 64 to 7c are jumped over
    for (int i = 0; i < 7; i++) begin
      program_table.push_back(itype_word(op_addiu, 5'd0, 5'd19, 16'd8));
    end
    program_table.push_back(itype_word(op_addiu, 5'd0, 5'd0, 16'h0055));      // 80
    program_table.push_back(rtype_word(5'd0, 5'd0, 5'd20, 5'd0, fn_addu));    // 84
    program_table.push_back(itype_word(op_addiu, 5'd0, 5'd21, 16'd9));        // 88
    program_table.push_back(jump_word(32'h0000_008c));                        // 8c
    // delay slot of the final loop writes no register
    program_table.push_back(itype_word(op_sw, 5'd0, 5'd0, 16'd8));            // 90
    for (int i = 0; i < program_table.size(); i++) begin
      imem[base + 8'(i)] <= program_table[i];
    end
  endtask

  task automatic expect_write(input word_t pc, input reg_addr_t rd, input word_t value);
    exp_pc.push_back(pc);
    exp_reg.push_back(rd);
    exp_val.push_back(value);
  endtask

  task automatic build_expected_trace();
    word_t r1;
    word_t r2;
    word_t r3;
    word_t r5;
    word_t r6;
    word_t r7;
    word_t r11;
    r1  = (32'h0000_1234 << 16) | 32'h0000_5678;
    r2  = 32'd100;
    r3  = r1 + r2;
    r5  = r3 ^ r1;
    r6  = ($signed(r2) < $signed(r5)) ? 32'd1 : 32'd0;
    r7  = r6 << 4;
    r11 = r1;
    expect_write(32'h00, 5'd1, 32'h0000_1234 << 16);
    expect_write(32'h04, 5'd1, r1);
    expect_write(32'h08, 5'd2, r2);
    expect_write(32'h0c, 5'd3, r3);
    expect_write(32'h10, 5'd4, r3 - r1);
    expect_write(32'h14, 5'd5, r5);
    expect_write(32'h18, 5'd6, r6);
    expect_write(32'h1c, 5'd7, r7);
    expect_write(32'h20, 5'd8, r1 >> 8);
    expect_write(32'h24, 5'd9, r5 | r7);
    expect_write(32'h28, 5'd10, 32'h0000_0040);
    expect_write(32'h30, 5'd11, r11);
    expect_write(32'h34, 5'd12, r11 + r2);
    expect_write(32'h3c, 5'd13, 32'd1);
    expect_write(32'h48, 5'd15, 32'd3);
    expect_write(32'h54, 5'd16, 32'd5);
    expect_write(32'h58, 5'd17, 32'd6);
    expect_write(32'h60, 5'd18, 32'd7);
    // the $0 write is traced but reads of $0 stay zero
    expect_write(32'h80, 5'd0, 32'h0000_0055);
    expect_write(32'h84, 5'd20, 32'd0);
    expect_write(32'h88, 5'd21, 32'd9);
  endtask

  task automatic check_idle_ports(input string when);
    check_bit({"inst_en ", when}, 1'b0, inst_en);
    check_bit({"data_en ", when}, 1'b0, data_en);
    check_strobe({"data_wstrb ", when}, 4'h0, data_wstrb);
    check_strobe({"trace strobe ", when}, 4'h0, debug_rf_wstrb);
  endtask

  task automatic wait_for_fetch();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!inst_en) begin
      cycles++;
      if (cycles > fetch_timeout) begin
        stop_on_error("no instruction fetch after reset release");
      end
      @(negedge clock);
    end
  endtask

  task automatic wait_for_trace(input int index);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (debug_rf_wstrb == 4'h0) begin
      cycles++;
      if (cycles > trace_timeout) begin
        stop_on_error($sformatf("timed out waiting for trace entry %0d", index));
      end
      @(negedge clock);
    end
  endtask

  task automatic expect_no_trace(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clock);
      if (debug_rf_wstrb != 4'h0) begin
        stop_on_error("a register write retired after the program reached its final loop");
      end
    end
  endtask

  initial begin
    clock  = 1'b0;
    arst_n = 1'b0;
    inst_rdata <= '0;
    data_rdata <= '0;
    fill_memories();
    load_program();
    build_expected_trace();

    repeat (8) begin
      @(negedge clock);
      check_idle_ports("during reset");
    end
    arst_n = 1'b1;
    check_idle_ports("after reset");

    wait_for_fetch();
    check_word("first fetch address", reset_pc, inst_addr);
    // the instruction port only reads
    check_strobe("inst_wstrb on the first fetch", 4'h0, inst_wstrb);
    check_word("inst_wdata on the first fetch", 32'h0000_0000, inst_wdata);

    for (int n = 0; n < exp_pc.size(); n++) begin
      wait_for_trace(n);
      check_strobe($sformatf("trace %0d strobe", n), 4'hf, debug_rf_wstrb);
      check_word($sformatf("trace %0d pc", n), exp_pc[n], debug_pc);
      check_reg_addr($sformatf("trace %0d register", n), exp_reg[n], debug_rf_waddr);
      check_word($sformatf("trace %0d value", n), exp_val[n], debug_rf_wdata);
    end

    expect_no_trace(quiet_cycles);
    check_word("stored word at 0x44", (32'h0000_1234 << 16) | 32'h0000_5678, dmem[8'h11]);

    $display("RESULT: PASS");
    $finish;
  end

endmodule : tb_cpu_core

`default_nettype wire

/* vlog.f */
cpu_pkg.sv
register_file.sv
if_stage.sv
id_stage.sv
ex_stage.sv
mem_stage.sv
wb_stage.sv
cpu_core.sv
cpu_core_sva.sv
tb_cpu_core.sv

/* wb_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_stage (
  input  wire                     clock,
  input  wire                     arst_n,
  input  wire                     ms_valid,
  input  wire cpu_pkg::word_t     ms_pc,
  input  wire cpu_pkg::word_t     ms_result,
  input  wire cpu_pkg::reg_addr_t ms_dest,
  input  wire                     ms_dest_we,
  output logic                    rf_we,
  output cpu_pkg::reg_addr_t      rf_waddr,
  output cpu_pkg::word_t          rf_wdata,
  output logic                    ws_fwd_valid,
  output logic                    ws_fwd_we,
  output cpu_pkg::reg_addr_t      ws_fwd_dest,
  output cpu_pkg::word_t          ws_fwd_value,
  output cpu_pkg::word_t          debug_pc,
  output cpu_pkg::strobe_t        debug_rf_wstrb,
  output cpu_pkg::reg_addr_t      debug_rf_waddr,
  output cpu_pkg::word_t          debug_rf_wdata
);
  import cpu_pkg::*;

  logic      valid;
  word_t     pc;
  word_t     result;
  reg_addr_t dest;
  logic      dest_we;

  // last stage, never stalls
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid <= 1'b0;
    end else begin
      valid <= ms_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (ms_valid) begin
      pc      <= ms_pc;
      result  <= ms_result;
      dest    <= ms_dest;
      dest_we <= ms_dest_we;
    end
  end

  assign rf_we    = valid && dest_we;
  assign rf_waddr = dest;
  assign rf_wdata = result;

  assign ws_fwd_valid = valid;
  assign ws_fwd_we    = dest_we;
  assign ws_fwd_dest  = dest;
  assign ws_fwd_value = result;

  // trace mirrors the register write, $0 included
  assign debug_pc       = pc;
  assign debug_rf_wstrb = {4{rf_we}};
  assign debug_rf_waddr = dest;
  assign debug_rf_wdata = result;

endmodule : wb_stage

`default_nettype wire
